// File: sources.f
verilog/nids_cfg_pkg.sv
verilog/nids_flow_pkg.sv
verilog/pkt_framer.sv
verilog/ftp_site_exec_dfa.sv
verilog/stream_enable_table.sv
verilog/regex_context_unit.sv
verilog/nids_top.sv
testbench/nids_tb.sv

// File: testbench/nids_stimulus.hex
// Words OOAAAA, OO opcode, AAAA argument, several words per line
// 01 enable write and 02 packet header: stream in the high byte, flag in the low byte
// 03 byte, 04 last byte, 05 expected count, 06 expected fired, FF end
// Rule enables for streams 1 to 5
010101 010201 010301 010401 010501
// Nothing counted before the first packet
050000 060000
// Stream 1 new, one full pattern
020101 030053 030049 030054 030045 030020 030045 030058 030045 040043 050001 060001
// Stream 2 new, pattern twice in one packet, counted once
020201 030053 030049 030054 030045 030020 030045 030058 030045 030043
030053 030049 030054 030045 030020 030045 030058 030045 040043 050002 060001
// Stream 1 split, head "x SITE " then tail "EXEC"
020100 030078 030020 030053 030049 030054 030045 040020 050002 060000
020100 030045 030058 030045 040043 050003 060001
// Stream 2 split, tail marked new does not count
020200 030053 030049 030054 030045 040020 050003 060000
020201 030045 030058 030045 040043 050003 060000
// Stream 4 stores a clean state, then its rule is switched off
020401 030048 030045 03004C 04004F 050003 060000 010400
// Full pattern on the disabled stream is dropped
020401 030053 030049 030054 030045 030020 030045 030058 030045 040043 050003 060000
// Head on disabled stream 4 is not saved, tail after re-enable misses
020400 030053 030049 030054 030045 040020 050003 060000 010401
020400 030045 030058 030045 040043 050003 060000
// Interleaved, head on stream 3, full packet on stream 5, tail on stream 3
020301 030053 030049 030054 040045 050003 060000
020501 030053 030049 030054 030045 030020 030045 030058 030045 040043 050004 060001
020300 030020 030045 030058 030045 040043 050005 060001
FF0000

// File: testbench/nids_tb.sv
`timescale 1ns/1ps

module nids_tb;

  // Idle cycles after each last byte, commit plus counter update plus margin
  localparam int GAP_CYCLES  = nids_cfg_pkg::COMMIT_DELAY + 2;
  localparam int MAX_RECORDS = 512;

  // Record opcodes in the top byte of each stimulus word
  localparam logic [7:0] OP_CFG   = 8'h01;
  localparam logic [7:0] OP_HDR   = 8'h02;
  localparam logic [7:0] OP_BYTE  = 8'h03;
  localparam logic [7:0] OP_LAST  = 8'h04;
  localparam logic [7:0] OP_COUNT = 8'h05;
  localparam logic [7:0] OP_FIRED = 8'h06;
  localparam logic [7:0] OP_END   = 8'hFF;

  logic                              clk;
  logic                              rst_n;
  nids_flow_pkg::char_beat_t         in_byte;
  logic                              sop;
  logic                              eop;
  logic                              new_stream;
  logic [nids_cfg_pkg::STREAM_W-1:0] stream_id;
  nids_flow_pkg::cfg_write_t         cfg;
  logic [nids_cfg_pkg::COUNT_W-1:0]  count;
  logic                              fired;

  logic [23:0] stim_mem [MAX_RECORDS];
  int          num_records = 0;
  int          errors      = 0;
  int          checks      = 0;

  nids_top #(
    .NUM_STREAMS (64)
  ) dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_byte    (in_byte),
    .sop        (sop),
    .eop        (eop),
    .new_stream (new_stream),
    .stream_id  (stream_id),
    .cfg        (cfg),
    .count      (count),
    .fired      (fired)
  );

  // 4 ns clock
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog, budget scales with the number of records
  initial
  begin
    wait (num_records > 0);
    repeat (num_records * 20 + 200) @(posedge clk);
    $display("Timeout: stimulus not finished after %0d cycles", num_records * 20 + 200);
    $display("Simulation FAILED");
    $finish;
  end

  // Inputs move 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    in_byte.valid = 1'b0;
    in_byte.data  = '0;
    sop           = 1'b0;
    eop           = 1'b0;
    cfg.wr        = 1'b0;
    cfg.wr_stream = '0;
    cfg.wr_enable = 1'b0;
  endtask

  // Records up to the end marker
  function automatic int count_records();
    int n;
    n = 0;
    while (n < MAX_RECORDS && !$isunknown(stim_mem[n]) && stim_mem[n][23:16] != OP_END)
      n++;
    return n;
  endfunction

  initial
  begin
    logic [7:0]  op;
    logic [15:0] arg;
    logic        first_byte;
    rst_n      = 1'b0;
    stream_id  = '0;
    new_stream = 1'b0;
    first_byte = 1'b0;
    drive_idle();
    $readmemh("testbench/nids_stimulus.hex", stim_mem);
    num_records = count_records();
    if (num_records >= MAX_RECORDS || stim_mem[num_records][23:16] !== OP_END)
    begin
      errors++;
      $display("Stimulus file has no end record within %0d words", MAX_RECORDS);
    end
    // Reset held for 16 cycles
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    for (int i = 0; i < num_records && i < MAX_RECORDS; i++)
    begin
      op  = stim_mem[i][23:16];
      arg = stim_mem[i][15:0];
      case (op)
        // Single-cycle enable write
        OP_CFG:
        begin
          cfg.wr        = 1'b1;
          cfg.wr_stream = arg[13:8];
          cfg.wr_enable = arg[0];
          next_cycle();
          drive_idle();
        end
        // Stream tag set up ahead of the first byte
        OP_HDR:
        begin
          stream_id  = arg[13:8];
          new_stream = arg[0];
          first_byte = 1'b1;
        end
        // Bytes back to back, sop on the first and eop on the last
        OP_BYTE, OP_LAST:
        begin
          in_byte.valid = 1'b1;
          in_byte.data  = arg[7:0];
          sop           = first_byte;
          eop           = (op == OP_LAST);
          next_cycle();
          drive_idle();
          first_byte = 1'b0;
          if (op == OP_LAST)
            repeat (GAP_CYCLES) next_cycle();
        end
        OP_COUNT:
        begin
          checks++;
          if (count !== arg[nids_cfg_pkg::COUNT_W-1:0])
          begin
            errors++;
            $display("[FAIL] count: got %h, expected %h at record %0d", count, arg, i);
          end
        end
        OP_FIRED:
        begin
          checks++;
          if (fired !== arg[0])
          begin
            errors++;
            $display("[FAIL] fired: got %h, expected %h at record %0d", fired, arg[0], i);
          end
        end
        default:
        begin
          errors++;
          $display("Stimulus record %0d has an unknown opcode %h", i, op);
        end
      endcase
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: verilog/nids_top.sv
`timescale 1ns/1ps

module nids_top #(
  parameter int NUM_STREAMS = 64
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  nids_flow_pkg::char_beat_t         in_byte,
  input  logic                              sop,
  input  logic                              eop,
  input  logic                              new_stream,
  input  logic [nids_cfg_pkg::STREAM_W-1:0] stream_id,
  input  nids_flow_pkg::cfg_write_t         cfg,
  output logic [nids_cfg_pkg::COUNT_W-1:0]  count,
  output logic                              fired
);

  nids_flow_pkg::char_beat_t beat;
  nids_flow_pkg::pkt_ctrl_t  ctrl;
  logic                      enable;

  // Framing stage, byte register and packet strobes
  pkt_framer u_framer (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_byte    (in_byte),
    .sop        (sop),
    .eop        (eop),
    .stream_id  (stream_id),
    .new_stream (new_stream),
    .beat       (beat),
    .ctrl       (ctrl)
  );

  // Rule enables beside the pipeline, looked up by the held stream id
  stream_enable_table #(
    .NUM_STREAMS (NUM_STREAMS)
  ) u_enable_table (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .rd_stream (ctrl.stream_id),
    .enable    (enable)
  );

  // Stream context, automaton and counter
  regex_context_unit #(
    .NUM_STREAMS (NUM_STREAMS)
  ) u_context (
    .clk    (clk),
    .rst_n  (rst_n),
    .beat   (beat),
    .ctrl   (ctrl),
    .enable (enable),
    .count  (count),
    .fired  (fired)
  );

endmodule

// File: verilog/regex_context_unit.sv
`timescale 1ns/1ps

module regex_context_unit #(
  parameter int NUM_STREAMS = 64
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  nids_flow_pkg::char_beat_t        beat,
  input  nids_flow_pkg::pkt_ctrl_t         ctrl,
  input  logic                             enable,
  output logic [nids_cfg_pkg::COUNT_W-1:0] count,
  output logic                             fired
);

  // Saved automaton state, one word per stream
  logic [nids_cfg_pkg::STATE_W-1:0] state_mem [NUM_STREAMS];

  logic [nids_cfg_pkg::STATE_W-1:0] restored_state;
  logic [nids_cfg_pkg::STATE_W-1:0] state_out;
  logic                             accept_out;
  logic [nids_cfg_pkg::STATE_W-1:0] state_out_r;
  logic                             accept_out_r;
  logic                             spec_match;

  // Restore source for the packet start
  // New stream starts from the idle state, else resume where it stopped
  assign restored_state = ctrl.new_stream ? '0 : state_mem[ctrl.stream_id];

  // First byte and the restored state enter the automaton together,
  // its state register holds the result one cycle later
  ftp_site_exec_dfa u_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (beat.data),
    .char_in_vld  (beat.valid),
    .state_in     (restored_state),
    .state_in_vld (ctrl.load_state),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

  // Automaton outputs registered once for timing
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      accept_out_r <= 1'b0;
    else
      accept_out_r <= accept_out;
  end

  always_ff @(posedge clk)
  begin
    state_out_r <= state_out;
  end

  // Save at commit only when the rule is on for this stream
  // a disabled stream keeps its older state
  always_ff @(posedge clk)
  begin
    if (ctrl.commit && enable)
      state_mem[ctrl.stream_id] <= state_out_r;
  end

  // Speculative per-packet flag and the committed counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count      <= '0;
      spec_match <= 1'b0;
    end
    else
    begin
      // Fresh flag for every packet
      if (ctrl.load_state)
        spec_match <= 1'b0;
      // Any accept in the packet sets it, later ones change nothing
      if (accept_out_r)
        spec_match <= 1'b1;
      if (ctrl.commit)
      begin
        if (enable)
        begin
          if (spec_match)
            count <= count + 1'b1;
        end
        else
          spec_match <= 1'b0;
      end
    end
  end

  // Level for the current packet
  assign fired = spec_match;

  // Restore and save of one stream must never overlap
  property p_load_commit_apart;
    @(posedge clk) disable iff (!rst_n)
      !(ctrl.load_state && ctrl.commit);
  endproperty

  a_load_commit_apart : assert property (p_load_commit_apart)
    else $error("regex_context_unit: load_state and commit together, stream=%h",
                ctrl.stream_id);

endmodule

// File: verilog/stream_enable_table.sv
`timescale 1ns/1ps

module stream_enable_table #(
  parameter int NUM_STREAMS = 64
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  nids_flow_pkg::cfg_write_t         cfg,
  input  logic [nids_cfg_pkg::STREAM_W-1:0] rd_stream,
  output logic                              enable
);

  // One rule enable per stream, all off after reset
  logic [NUM_STREAMS-1:0] enable_q;

  // Written by the configuration strobe, visible the next cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      enable_q <= '0;
    else if (cfg.wr)
      enable_q[cfg.wr_stream] <= cfg.wr_enable;
  end

  // Read port, sampled downstream at commit
  assign enable = enable_q[rd_stream];

  // Writes stay inside the table
  property p_wr_in_range;
    @(posedge clk) disable iff (!rst_n)
      cfg.wr |-> (cfg.wr_stream < NUM_STREAMS);
  endproperty

  a_wr_in_range : assert property (p_wr_in_range)
    else $error("stream_enable_table: write to stream %h beyond %0d entries",
                cfg.wr_stream, NUM_STREAMS);

endmodule

// File: verilog/ftp_site_exec_dfa.sv
`timescale 1ns/1ps

module ftp_site_exec_dfa (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [nids_cfg_pkg::CHAR_W-1:0]  char_in,
  input  logic                             char_in_vld,
  input  logic [nids_cfg_pkg::STATE_W-1:0] state_in,
  input  logic                             state_in_vld,
  output logic [nids_cfg_pkg::STATE_W-1:0] state_out,
  output logic                             accept_out
);

  // State is the length of the matched prefix of "SITE EXEC"
  localparam logic [nids_cfg_pkg::STATE_W-1:0] FINAL_STATE = 9;

  logic [nids_cfg_pkg::STATE_W-1:0] state_q;
  logic [nids_cfg_pkg::STATE_W-1:0] base_state;
  logic [nids_cfg_pkg::STATE_W-1:0] next_state;
  logic                             accept_q;

  // Expected byte at each prefix position
  function automatic logic [nids_cfg_pkg::CHAR_W-1:0] pattern_char(
    input logic [nids_cfg_pkg::STATE_W-1:0] pos
  );
    logic [nids_cfg_pkg::CHAR_W-1:0] c;
    case (pos)
      0: c = 8'h53; // S
      1: c = 8'h49; // I
      2: c = 8'h54; // T
      3: c = 8'h45; // E
      4: c = 8'h20; // space
      5: c = 8'h45; // E
      6: c = 8'h58; // X
      7: c = 8'h45; // E
      8: c = 8'h43; // C
      default: c = '0;
    endcase
    return c;
  endfunction

  // One transition of the prefix automaton
  // 'S' occurs only at the head of the pattern, so any mismatch
  // falls back to either one matched byte or none
  function automatic logic [nids_cfg_pkg::STATE_W-1:0] step(
    input logic [nids_cfg_pkg::STATE_W-1:0] cur,
    input logic [nids_cfg_pkg::CHAR_W-1:0]  c
  );
    logic [nids_cfg_pkg::STATE_W-1:0] nxt;
    if ((cur < FINAL_STATE) && (c == pattern_char(cur)))
      nxt = cur + 1'b1;
    else if (c == pattern_char('0))
      nxt = 1;
    else
      nxt = '0;
    return nxt;
  endfunction

  // Loaded state takes over before the byte of the same cycle is applied
  always_comb
  begin
    base_state = state_in_vld ? state_in : state_q;
    next_state = char_in_vld ? step(base_state, char_in) : base_state;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= '0;
      accept_q <= 1'b0;
    end
    else
    begin
      state_q  <= next_state;
      // Pulse only on the byte that completes the pattern
      accept_q <= char_in_vld && (next_state == FINAL_STATE);
    end
  end

  assign state_out  = state_q;
  assign accept_out = accept_q;

endmodule

// File: verilog/pkt_framer.sv
`timescale 1ns/1ps

module pkt_framer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  nids_flow_pkg::char_beat_t         in_byte,
  input  logic                              sop,
  input  logic                              eop,
  input  logic [nids_cfg_pkg::STREAM_W-1:0] stream_id,
  input  logic                              new_stream,
  output nids_flow_pkg::char_beat_t         beat,
  output nids_flow_pkg::pkt_ctrl_t          ctrl
);

  logic                                beat_vld_q;
  logic [nids_cfg_pkg::CHAR_W-1:0]     beat_data_q;
  logic                                load_q;
  logic [nids_cfg_pkg::STREAM_W-1:0]   stream_q;
  logic                                new_q;
  // Bit 0 is the registered end of packet, the top bit is the commit strobe
  logic [nids_cfg_pkg::COMMIT_DELAY:0] commit_sr;

  // Control flops, cleared at reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      beat_vld_q <= 1'b0;
      load_q     <= 1'b0;
      commit_sr  <= '0;
    end
    else
    begin
      beat_vld_q <= in_byte.valid;
      // Load strobe lines up with the registered first byte
      load_q     <= sop & in_byte.valid;
      commit_sr  <= {commit_sr[nids_cfg_pkg::COMMIT_DELAY-1:0], eop & in_byte.valid};
    end
  end

  // Byte payload and the stream tag held until the next packet
  always_ff @(posedge clk)
  begin
    beat_data_q <= in_byte.data;
    if (sop)
    begin
      stream_q <= stream_id;
      new_q    <= new_stream;
    end
  end

  assign beat = '{valid: beat_vld_q, data: beat_data_q};

  assign ctrl = '{load_state: load_q,
                  commit:     commit_sr[nids_cfg_pkg::COMMIT_DELAY],
                  stream_id:  stream_q,
                  new_stream: new_q};

  // Source keeps packets apart, next start only once the last commit is out
  property p_sop_after_commit;
    @(posedge clk) disable iff (!rst_n)
      sop |-> (commit_sr == '0);
  endproperty

  a_sop_after_commit : assert property (p_sop_after_commit)
    else $error("pkt_framer: sop while commit pending, commit_sr=%h", commit_sr);

endmodule

// File: verilog/nids_flow_pkg.sv
package nids_flow_pkg;

  // Bundles that travel between the pipeline stages

  // One byte with its valid bit
  // Framer to context unit
  typedef struct packed {
    logic                            valid;
    logic [nids_cfg_pkg::CHAR_W-1:0] data;
  } char_beat_t;

  // Packet control from the framer
  // load_state and commit are single-cycle strobes
  // stream_id and new_stream are held for the whole packet
  typedef struct packed {
    logic                              load_state;
    logic                              commit;
    logic [nids_cfg_pkg::STREAM_W-1:0] stream_id;
    logic                              new_stream;
  } pkt_ctrl_t;

  // Enable write into the per-stream rule table
  typedef struct packed {
    logic                              wr;
    logic [nids_cfg_pkg::STREAM_W-1:0] wr_stream;
    logic                              wr_enable;
  } cfg_write_t;

endpackage

// File: verilog/nids_cfg_pkg.sv
package nids_cfg_pkg;

  // Widths and sizes shared by the matcher datapath

  // One payload byte per cycle
  localparam int CHAR_W = 8;

  // Automaton state word
  // Wide enough for larger rule sets than the single one compiled here
  localparam int STATE_W = 11;

  // Stream identifier carried with each packet
  localparam int STREAM_W = 6;

  // Committed match counter
  localparam int COUNT_W = 16;

  // Cycles from the framed end of packet to the commit strobe
  // Covers the automaton and its output register
  localparam int COMMIT_DELAY = 3;

endpackage
